/* ahb_arbiter.sv */
/*
  Round-robin arbiter for two masters on one AHB-Lite bus.
  A master must hold its address phase until HREADY and may only issue NONSEQ while granted.
*/
`timescale 1ns/1ns

module ahb_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic [1:0]                            m_hbusreq_i,
  output logic [1:0]                            m_hgrant_o,

  input  logic [1:0][ahb_soc_pkg::PLEN-1:0]     m_haddr_i,
  input  logic [1:0]                            m_hwrite_i,
  input  logic [1:0][2:0]                       m_hsize_i,
  input  ahb_soc_pkg::htrans_e                  m_htrans_i [2],
  input  logic [1:0][ahb_soc_pkg::XLEN-1:0]     m_hwdata_i,

  ahb_if.master                                 bus
);

  ////////////////////////////
  // Grant state
  ////////////////////////////

  // Index of the master that owns the address phase
  logic grant_q;

  // Index of the master whose transfer is in the data phase
  logic owner_q;

  // The other master, which is the only candidate for a handover
  logic other;

  // High on an edge where the grant is allowed to move
  logic handover;

  assign other = ~grant_q;

  // The granted master may only lose the bus once its address phase is not pending,
  // that is when it is idle or has dropped its request, and the bus is ready
  assign handover = bus.hready &&
                    ((m_htrans_i[grant_q] == ahb_soc_pkg::IDLE) || !m_hbusreq_i[grant_q]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Master 0 holds the bus after reset
      grant_q <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      // Alternate only if the other master actually wants the bus
      if (handover && m_hbusreq_i[other]) begin
        grant_q <= other;
      end
      // Every edge with HREADY high starts a new data phase for the granted master
      if (bus.hready) begin
        owner_q <= grant_q;
      end
    end
  end

  // Grants are registered levels
  assign m_hgrant_o[0] = (grant_q == 1'b0);
  assign m_hgrant_o[1] = (grant_q == 1'b1);

  ////////////////////////////
  // Bus multiplexers
  ////////////////////////////

  // Address phase follows the grant
  assign bus.haddr  = m_haddr_i[grant_q];
  assign bus.hwrite = m_hwrite_i[grant_q];
  assign bus.hsize  = m_hsize_i[grant_q];
  assign bus.htrans = m_htrans_i[grant_q];

  // Select the bus whenever the granted master starts a transfer
  assign bus.hsel = (m_htrans_i[grant_q] == ahb_soc_pkg::NONSEQ);

  // Write data belongs to the transfer in the data phase, one phase behind the grant
  assign bus.hwdata = m_hwdata_i[owner_q];

endmodule

/* ahb_decoder.sv */
/*
  Address decoder for two slaves with a registered data-phase select.
  Unmapped addresses get a two-cycle ERROR from the decoder itself.
*/
`timescale 1ns/1ns

module ahb_decoder #(
  parameter logic [ahb_soc_pkg::PLEN-1:0] S0_BASE     = ahb_soc_pkg::S0_BASE,
  parameter logic [ahb_soc_pkg::PLEN-1:0] S1_BASE     = ahb_soc_pkg::S1_BASE,
  parameter int                           RANGE_WIDTH = ahb_soc_pkg::RANGE_WIDTH
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  ahb_if.slave  up,
  ahb_if.master dn [ahb_soc_pkg::SLAVES]
);

  localparam int PLEN   = ahb_soc_pkg::PLEN;
  localparam int XLEN   = ahb_soc_pkg::XLEN;
  localparam int SLAVES = ahb_soc_pkg::SLAVES;

  // Base of each slave, indexed by slave number
  localparam logic [PLEN-1:0] BASE [SLAVES] = '{S0_BASE, S1_BASE};

  logic [SLAVES-1:0]    match;
  logic [SLAVES-1:0]    sel_q;
  logic                 accept;
  logic                 miss;
  ahb_soc_pkg::dec_state_e state_q;

  // Return path of each slave, gathered so it can be muxed by index
  logic [XLEN-1:0]      s_hrdata [SLAVES];
  logic                 s_hready [SLAVES];
  ahb_soc_pkg::hresp_e  s_hresp  [SLAVES];

  // Muxed return path of the registered slave
  logic [XLEN-1:0]      mux_hrdata;
  logic                 mux_hready;
  ahb_soc_pkg::hresp_e  mux_hresp;

  ////////////////////////////
  // Address phase
  ////////////////////////////

  for (genvar i = 0; i < SLAVES; i++) begin : g_slave
    // Upper address bits decide the slave
    assign match[i] = (up.haddr[PLEN-1 -: RANGE_WIDTH] == BASE[i][PLEN-1 -: RANGE_WIDTH]);

    // The slave only sees HSEL on an edge that really accepts the address,
    // because its own HREADY cannot see a wait state of the other slave
    assign dn[i].hsel   = up.hsel & match[i] & up.hready;
    assign dn[i].haddr  = up.haddr;
    assign dn[i].hwrite = up.hwrite;
    assign dn[i].hsize  = up.hsize;
    assign dn[i].htrans = up.htrans;
    assign dn[i].hwdata = up.hwdata;

    assign s_hrdata[i] = dn[i].hrdata;
    assign s_hready[i] = dn[i].hready;
    assign s_hresp[i]  = dn[i].hresp;
  end

  assign accept = up.hsel && (up.htrans == ahb_soc_pkg::NONSEQ) && up.hready;
  assign miss   = (match == '0);

  ////////////////////////////
  // Data phase
  ////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q   <= '0;
      state_q <= ahb_soc_pkg::DATA;
    end else if (up.hready) begin
      // A new data phase starts on every ready edge, possibly with no slave
      sel_q   <= accept ? match : '0;
      state_q <= (accept && miss) ? ahb_soc_pkg::ERR1 : ahb_soc_pkg::DATA;
    end else if (state_q == ahb_soc_pkg::ERR1) begin
      // Second error cycle releases HREADY
      state_q <= ahb_soc_pkg::ERR2;
    end
  end

  // With nothing selected the bus reads as ready and OKAY
  always_comb begin
    mux_hrdata = '0;
    mux_hready = 1'b1;
    mux_hresp  = ahb_soc_pkg::OKAY;
    for (int i = 0; i < SLAVES; i++) begin
      if (sel_q[i]) begin
        mux_hrdata = s_hrdata[i];
        mux_hready = s_hready[i];
        mux_hresp  = s_hresp[i];
      end
    end
  end

  assign up.hrdata = mux_hrdata;
  assign up.hready = (state_q == ahb_soc_pkg::ERR1) ? 1'b0 :
                     (state_q == ahb_soc_pkg::ERR2) ? 1'b1 : mux_hready;
  assign up.hresp  = (state_q != ahb_soc_pkg::DATA) ? ahb_soc_pkg::ERROR : mux_hresp;

endmodule

/* ahb_if.sv */
/*
  AHB-Lite link between two blocks of the interconnect.
  HREADY is a single wire driven by the slave side, so there is no separate HREADYOUT.
*/
`timescale 1ns/1ns

interface ahb_if;

  // Address phase, driven by the upstream side
  logic                            hsel;
  logic [ahb_soc_pkg::PLEN-1:0]    haddr;
  logic                            hwrite;
  logic [2:0]                      hsize;
  ahb_soc_pkg::htrans_e            htrans;

  // Write data trails the address by one phase
  logic [ahb_soc_pkg::XLEN-1:0]    hwdata;

  // Data-phase return path from the slave side
  logic [ahb_soc_pkg::XLEN-1:0]    hrdata;
  logic                            hready;
  ahb_soc_pkg::hresp_e             hresp;

  // Upstream view, as used by the arbiter and by the decoder towards a slave
  modport master (
    output hsel, haddr, hwrite, hsize, htrans, hwdata,
    input  hrdata, hready, hresp
  );

  // Downstream view, as used by the decoder towards the arbiter and by the SRAMs
  modport slave (
    input  hsel, haddr, hwrite, hsize, htrans, hwdata,
    output hrdata, hready, hresp
  );

endinterface

/* ahb_soc.f */
ahb_soc_pkg.sv
ahb_if.sv
ahb_arbiter.sv
ahb_decoder.sv
ahb_sram_slave.sv
ahb_soc_top.sv
ahb_soc_tb.sv

/* ahb_soc_pkg.sv */
/*
  Shared widths, address map defaults and bus enums for the AHB-Lite interconnect.
  Only word-sized single transfers are supported across the whole design.
*/
package ahb_soc_pkg;

  ////////////////////////////
  // Bus widths
  ////////////////////////////

  // Data and address widths in bits
  localparam int XLEN = 32;
  localparam int PLEN = 32;

  // Number of decoded slaves behind the address decoder
  localparam int SLAVES = 2;

  ////////////////////////////
  // Encodings
  ////////////////////////////

  // Transfer type as seen on HTRANS; BUSY and SEQ never appear here
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Slave response; retry and split are not part of AHB-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // HSIZE code of a 32-bit transfer
  localparam logic [2:0] hsize_word = 3'b010;

  // Data-phase state of the decoder, ERR1 and ERR2 form the two-cycle error
  typedef enum logic [1:0] {
    DATA = 2'b00,
    ERR1 = 2'b01,
    ERR2 = 2'b10
  } dec_state_e;

  // Default address map, each slave owns 1 KiB
  localparam logic [PLEN-1:0] S0_BASE     = 32'h0000_0000;
  localparam logic [PLEN-1:0] S1_BASE     = 32'h0000_0400;
  localparam int              RANGE_WIDTH = 22;

endpackage

/* ahb_soc_tb.sv */
/*
  Testbench for the two-master AHB-Lite interconnect with its two SRAM slaves.
  Inputs change on the falling edge and responses are read at the falling edge.
  Each master issues single word transfers and waits for its own data phase to end.
*/
`timescale 1ns/1ns

module ahb_soc_tb;

  localparam int XLEN       = ahb_soc_pkg::XLEN;
  localparam int PLEN       = ahb_soc_pkg::PLEN;
  localparam int S0_WAIT    = 0;
  localparam int S1_WAIT    = 2;
  localparam int DEPTH_LOG2 = 8;
  localparam int N_OPS      = 32;
  localparam int SHIFT      = PLEN - ahb_soc_pkg::RANGE_WIDTH;
  localparam logic [31:0] SEED = 32'hea38_ca23;

  // About 200 transfers of up to 5 cycles each and a margin of four times
  localparam int MAX_CYCLES = 4000;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 hbusreq [2];
  logic [PLEN-1:0]      haddr [2];
  logic                 hwrite [2];
  logic [2:0]           hsize [2];
  ahb_soc_pkg::htrans_e htrans [2];
  logic [XLEN-1:0]      hwdata [2];
  wire  [1:0]           hgrant;
  logic [XLEN-1:0]      hrdata;
  logic                 hready;
  ahb_soc_pkg::hresp_e  hresp;

  // Outcome of the last transfer of each master
  logic [XLEN-1:0]      last_rdata [2];
  ahb_soc_pkg::hresp_e  last_resp [2];
  int                   last_lat [2];
  logic                 first_ready [2];
  ahb_soc_pkg::hresp_e  first_resp [2];

  // Reference memory, indexed by slave and word
  logic [XLEN-1:0]      ref_mem [2][2**DEPTH_LOG2];
  logic [PLEN-1:0]      addr_list [2][N_OPS];
  logic [31:0]          rng_st [2];
  int                   cycle_cnt = 0;
  logic                 arb_check = 1'b0;
  int                   last_owner = -1;

  always #20 clk = ~clk;

  ahb_soc_top #(.S0_WAIT(S0_WAIT), .S1_WAIT(S1_WAIT)) i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .m0_hbusreq_i (hbusreq[0]),
    .m0_haddr_i   (haddr[0]),
    .m0_hwrite_i  (hwrite[0]),
    .m0_hsize_i   (hsize[0]),
    .m0_htrans_i  (htrans[0]),
    .m0_hwdata_i  (hwdata[0]),
    .m0_hgrant_o  (hgrant[0]),
    .m1_hbusreq_i (hbusreq[1]),
    .m1_haddr_i   (haddr[1]),
    .m1_hwrite_i  (hwrite[1]),
    .m1_hsize_i   (hsize[1]),
    .m1_htrans_i  (htrans[1]),
    .m1_hwdata_i  (hwdata[1]),
    .m1_hgrant_o  (hgrant[1]),
    .hrdata_o     (hrdata),
    .hready_o     (hready),
    .hresp_o      (hresp)
  );

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic stop_with_error(input string what);
    $display("SIMULATION FAILED");
    $display("Error at %0t ns: %s", $time, what);
    $fatal(1, "run stopped after an error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("SIMULATION FAILED");
      $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Each master draws from its own stream so the two never compete for one state
  task automatic draw_random(input int m, output logic [31:0] value);
    rng_st[m] = xorshift32(rng_st[m]);
    value = rng_st[m];
  endtask

  // Slave index from the default map, or -1 for an unmapped address
  function automatic int decode_slave(input logic [PLEN-1:0] addr);
    if ((addr >> SHIFT) == (ahb_soc_pkg::S0_BASE >> SHIFT)) return 0;
    if ((addr >> SHIFT) == (ahb_soc_pkg::S1_BASE >> SHIFT)) return 1;
    return -1;
  endfunction

  function automatic logic [PLEN-1:0] word_addr(input int s, input logic [31:0] r);
    logic [PLEN-1:0] base;
    base = (s == 0) ? ahb_soc_pkg::S0_BASE : ahb_soc_pkg::S1_BASE;
    return base + (PLEN'(r[DEPTH_LOG2-1:0]) << 2);
  endfunction

  //////////////////////////////
  // Master drivers
  //////////////////////////////

  // One NONSEQ transfer, from the request up to the edge that ends its data phase
  task automatic drive_transfer(input int m, input logic write, input logic [PLEN-1:0] addr,
                                input logic [2:0] size, input logic [XLEN-1:0] wdata);
    @(negedge clk);
    hbusreq[m] = 1'b1;
    while (!hgrant[m]) @(negedge clk);
    haddr[m]  = addr;
    hwrite[m] = write;
    hsize[m]  = size;
    htrans[m] = ahb_soc_pkg::NONSEQ;
    // The address phase is held until the bus is ready
    while (!hready) @(negedge clk);
    @(posedge clk);
    @(negedge clk);
    htrans[m] = ahb_soc_pkg::IDLE;
    hwdata[m] = wdata;
    first_ready[m] = hready;
    first_resp[m]  = hresp;
    last_lat[m]    = 1;
    while (!hready) begin
      @(negedge clk);
      last_lat[m]++;
    end
    last_rdata[m] = hrdata;
    last_resp[m]  = hresp;
    @(posedge clk);
  endtask

  task automatic check_transfer(input int m, input logic write, input logic [PLEN-1:0] addr,
                                input logic [2:0] size, input logic [XLEN-1:0] wdata);
    int s;
    int word;
    s    = decode_slave(addr);
    word = addr[DEPTH_LOG2+1:2];
    drive_transfer(m, write, addr, size, wdata);
    if ((s < 0) || (size != ahb_soc_pkg::hsize_word)) begin
      // An unmapped address or a wrong size gives ERROR with a wait cycle and then with ready
      expect_equal("hready_o in first error cycle", 0, first_ready[m]);
      expect_equal("hresp_o in first error cycle", ahb_soc_pkg::ERROR, first_resp[m]);
      expect_equal("hresp_o in second error cycle", ahb_soc_pkg::ERROR, last_resp[m]);
      expect_equal("cycles to hready_o on error", 2, last_lat[m]);
    end else begin
      expect_equal("hresp_o", ahb_soc_pkg::OKAY, last_resp[m]);
      expect_equal("cycles to hready_o", 1 + ((s == 0) ? S0_WAIT : S1_WAIT), last_lat[m]);
      if (write) begin
        ref_mem[s][word] = wdata;
      end else begin
        expect_equal("hrdata_o", ref_mem[s][word], last_rdata[m]);
      end
    end
  endtask

  // Random words go to both slaves in turn and are all read back afterwards
  task automatic write_then_read(input int m);
    logic [31:0] r;
    logic [31:0] data;
    for (int i = 0; i < N_OPS; i++) begin
      draw_random(m, r);
      draw_random(m, data);
      addr_list[m][i] = word_addr(i % 2, r);
      check_transfer(m, 1'b1, addr_list[m][i], ahb_soc_pkg::hsize_word, data);
    end
    for (int i = 0; i < N_OPS; i++) begin
      check_transfer(m, 1'b0, addr_list[m][i], ahb_soc_pkg::hsize_word, '0);
    end
  endtask

  //////////////////////////////
  // Bus monitor and timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle_cnt++;
    assert (cycle_cnt < MAX_CYCLES) else stop_with_error("timeout, the tests did not finish");
    if (rst_n) begin
      assert (hgrant != 2'b11) else stop_with_error("both masters hold a grant at once");
      // An accepted address phase belongs to the granted master
      for (int g = 0; g < 2; g++) begin
        if (hgrant[g] && (htrans[g] == ahb_soc_pkg::NONSEQ) && hready) begin
          if (arb_check) begin
            assert (g != last_owner) else
              stop_with_error($sformatf("master %0d won two transfers in a row", g));
          end
          last_owner = g;
        end
      end
    end
  end

  initial begin
    logic [31:0]     r;
    logic [PLEN-1:0] a;
    rst_n = 1'b0;
    for (int m = 0; m < 2; m++) begin
      hbusreq[m] = 1'b0;
      haddr[m]   = '0;
      hwrite[m]  = 1'b0;
      hsize[m]   = ahb_soc_pkg::hsize_word;
      htrans[m]  = ahb_soc_pkg::IDLE;
      hwdata[m]  = '0;
    end
    rng_st[0] = SEED;
    rng_st[1] = xorshift32(~SEED);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle bus after reset
    expect_equal("hready_o", 1, hready);
    expect_equal("hresp_o", ahb_soc_pkg::OKAY, hresp);
    expect_equal("m0_hgrant_o", 1, hgrant[0]);

    // Master 0 alone checks the wait states on every transfer
    write_then_read(0);

    // Unmapped read, then a normal write and read back
    draw_random(0, r);
    check_transfer(0, 1'b0, 32'h0001_0000 | r, ahb_soc_pkg::hsize_word, '0);
    draw_random(0, r);
    a = word_addr(1, r);
    check_transfer(0, 1'b1, a, ahb_soc_pkg::hsize_word, r);
    check_transfer(0, 1'b0, a, ahb_soc_pkg::hsize_word, '0);

    // A halfword write is refused by the slave and leaves the word unchanged
    check_transfer(0, 1'b1, a, 3'b001, ~r);
    check_transfer(0, 1'b0, a, ahb_soc_pkg::hsize_word, '0);

    // Both masters request for the whole phase
    @(negedge clk);
    arb_check  = 1'b1;
    last_owner = -1;
    fork
      write_then_read(0);
      write_then_read(1);
    join

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* ahb_soc_top.sv */
/*
  Two masters, one round-robin arbiter, one decoder and two SRAM slaves.
  The response signals are shared, each master tracks its own transfers by its grant.
*/
`timescale 1ns/1ns

module ahb_soc_top #(
  parameter int                           S0_WAIT     = 0,
  parameter int                           S1_WAIT     = 2,
  parameter logic [ahb_soc_pkg::PLEN-1:0] S0_BASE     = ahb_soc_pkg::S0_BASE,
  parameter logic [ahb_soc_pkg::PLEN-1:0] S1_BASE     = ahb_soc_pkg::S1_BASE,
  parameter int                           RANGE_WIDTH = ahb_soc_pkg::RANGE_WIDTH
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Master 0
  input  logic                          m0_hbusreq_i,
  input  logic [ahb_soc_pkg::PLEN-1:0]  m0_haddr_i,
  input  logic                          m0_hwrite_i,
  input  logic [2:0]                    m0_hsize_i,
  input  ahb_soc_pkg::htrans_e          m0_htrans_i,
  input  logic [ahb_soc_pkg::XLEN-1:0]  m0_hwdata_i,
  output logic                          m0_hgrant_o,

  // Master 1
  input  logic                          m1_hbusreq_i,
  input  logic [ahb_soc_pkg::PLEN-1:0]  m1_haddr_i,
  input  logic                          m1_hwrite_i,
  input  logic [2:0]                    m1_hsize_i,
  input  ahb_soc_pkg::htrans_e          m1_htrans_i,
  input  logic [ahb_soc_pkg::XLEN-1:0]  m1_hwdata_i,
  output logic                          m1_hgrant_o,

  // Shared return path
  output logic [ahb_soc_pkg::XLEN-1:0]  hrdata_o,
  output logic                          hready_o,
  output ahb_soc_pkg::hresp_e           hresp_o
);

  ahb_if bus_m ();
  ahb_if bus_s [ahb_soc_pkg::SLAVES] ();

  // Transfer types gathered per master for the arbiter
  ahb_soc_pkg::htrans_e m_htrans [2];

  assign m_htrans[0] = m0_htrans_i;
  assign m_htrans[1] = m1_htrans_i;

  ahb_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_hbusreq_i ({m1_hbusreq_i, m0_hbusreq_i}),
    .m_hgrant_o  ({m1_hgrant_o, m0_hgrant_o}),
    .m_haddr_i   ({m1_haddr_i, m0_haddr_i}),
    .m_hwrite_i  ({m1_hwrite_i, m0_hwrite_i}),
    .m_hsize_i   ({m1_hsize_i, m0_hsize_i}),
    .m_htrans_i  (m_htrans),
    .m_hwdata_i  ({m1_hwdata_i, m0_hwdata_i}),
    .bus         (bus_m)
  );

  ahb_decoder #(
    .S0_BASE     (S0_BASE),
    .S1_BASE     (S1_BASE),
    .RANGE_WIDTH (RANGE_WIDTH)
  ) i_decoder (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .up      (bus_m),
    .dn      (bus_s)
  );

  // Slave 0 and slave 1 differ only in their wait states
  ahb_sram_slave #(.WAIT_CYCLES(S0_WAIT)) i_sram0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (bus_s[0])
  );

  ahb_sram_slave #(.WAIT_CYCLES(S1_WAIT)) i_sram1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (bus_s[1])
  );

  assign hrdata_o = bus_m.hrdata;
  assign hready_o = bus_m.hready;
  assign hresp_o  = bus_m.hresp;

endmodule

/* ahb_sram_slave.sv */
/*
  Single-port word SRAM behind an AHB-Lite slave port.
  Only word transfers are accepted, any other HSIZE gets a two-cycle ERROR.
*/
`timescale 1ns/1ns

module ahb_sram_slave #(
  parameter int WAIT_CYCLES = 0,
  parameter int DEPTH_LOG2  = 8
) (
  input  logic clk_i,
  input  logic rst_n_i,
  ahb_if.slave bus
);

  localparam int XLEN = ahb_soc_pkg::XLEN;

  // Counter width, kept at least one bit for a zero-wait slave
  localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  logic [XLEN-1:0]       mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] addr_q;
  logic                  write_q;
  logic                  active_q;
  logic [CW-1:0]         cnt_q;
  logic                  err1_q;
  logic                  err2_q;
  logic                  accept;
  logic                  bad_size;

  ////////////////////////////
  // Address phase
  ////////////////////////////

  assign accept   = bus.hsel && (bus.htrans == ahb_soc_pkg::NONSEQ) && bus.hready;
  assign bad_size = (bus.hsize != ahb_soc_pkg::hsize_word);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      err1_q   <= 1'b0;
      err2_q   <= 1'b0;
    end else begin
      // HREADY is low in ERR1, so no transfer can be accepted there
      err1_q <= accept && bad_size;
      err2_q <= err1_q;
      if (accept) begin
        active_q <= !bad_size;
        cnt_q    <= bad_size ? '0 : CW'(WAIT_CYCLES);
      end else begin
        if (bus.hready) begin
          active_q <= 1'b0;
        end
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  // Word address and direction of the pending transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= bus.haddr[DEPTH_LOG2+1:2];
      write_q <= bus.hwrite;
    end
  end

  ////////////////////////////
  // Data phase
  ////////////////////////////

  // The write lands on the edge that ends the data phase
  always_ff @(posedge clk_i) begin
    if (active_q && write_q && bus.hready) begin
      mem[addr_q] <= bus.hwdata;
    end
  end

  assign bus.hrdata = mem[addr_q];
  assign bus.hready = !err1_q && (cnt_q == '0);
  assign bus.hresp  = (err1_q || err2_q) ? ahb_soc_pkg::ERROR : ahb_soc_pkg::OKAY;

endmodule
